//--- apb_map_pkg.sv
// APB register map of the sonar telemetry block
// Bus types, register offsets and field positions

package apb_map_pkg;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	//======================================================================
	//  Register offsets
	//======================================================================

	localparam apb_addr_t REG_SAMPLE     = 8'h00; // Read pops the FIFO
	localparam apb_addr_t REG_STATUS     = 8'h04; // Write clears overflow count
	localparam apb_addr_t REG_CONTROL    = 8'h08; // Sensor enable mask
	localparam apb_addr_t REG_LAST_DIST0 = 8'h0C; // First of four

	localparam int LAST_DIST_STRIDE = 4; // Byte step between last-distance regs

	//======================================================================
	//  Field positions
	//======================================================================

	localparam int SAMPLE_VALID_BIT = 31; // Head entry present

	localparam int STATUS_LEVEL_LSB = 0;
	localparam int STATUS_LEVEL_W   = 8;
	localparam int STATUS_OVF_LSB   = 8;
	localparam int STATUS_OVF_W     = 16;

	localparam int CONTROL_MASK_LSB = 0;

endpackage

//--- apb_telemetry.sv
// APB register block for the sonar subsystem
// Control mask, FIFO status and readout, last distance per sensor
`timescale 1ns/1ps

module apb_telemetry (
	input  logic                   clock_50,
	input  logic                   reset,
	// APB slave, zero wait states
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  apb_map_pkg::apb_addr_t paddr,
	input  apb_map_pkg::apb_data_t pwdata,
	output apb_map_pkg::apb_data_t prdata,
	// Scanner side
	input  robot_cfg_pkg::sample_t sample,
	input  logic                   sample_valid,
	// FIFO side
	input  robot_cfg_pkg::sample_t fifo_head,
	input  logic [7:0]             fifo_level,
	input  logic [15:0]            overflow_count,
	output logic                   pop,
	output logic                   clear_overflow,
	output robot_cfg_pkg::sensor_mask_t sensor_mask
);
	import robot_cfg_pkg::*;
	import apb_map_pkg::*;

	logic  access;                     // Access phase
	logic  wr_en;
	logic  rd_en;
	logic  fifo_has_data;
	dist_t last_dist [NUM_SENSORS];

	assign access        = psel && penable;
	assign wr_en         = access && pwrite;
	assign rd_en         = access && !pwrite;
	assign fifo_has_data = (fifo_level != 8'd0);

	//======================================================================
	//  Side effects of accesses
	//======================================================================

	// Pop lands on the edge that closes the SAMPLE read
	assign pop            = rd_en && (paddr == REG_SAMPLE) && fifo_has_data;
	assign clear_overflow = wr_en && (paddr == REG_STATUS); // Any data value

	// Control register
	always_ff @(posedge clock_50) begin
		if (reset)
			sensor_mask <= '0; // Nothing scanned until host enables
		else if (wr_en && (paddr == REG_CONTROL))
			sensor_mask <= pwdata[CONTROL_MASK_LSB +: NUM_SENSORS];
	end

	// Latest distance per channel, fed straight from the scanner
	// so samples dropped by a full FIFO still show up here
	always_ff @(posedge clock_50) begin
		if (reset) begin
			for (int i = 0; i < NUM_SENSORS; i++)
				last_dist[i] <= '0;
		end else if (sample_valid) begin
			last_dist[sample[DIST_W +: ID_W]] <= sample[DIST_W-1:0];
		end
	end

	//======================================================================
	//  Read mux
	//======================================================================

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_SAMPLE: begin
					prdata[SAMPLE_VALID_BIT] = fifo_has_data;
					if (fifo_has_data)
						prdata[$bits(sample_t)-1:0] = fifo_head; // Id and distance
				end
				REG_STATUS: begin
					prdata[STATUS_LEVEL_LSB +: STATUS_LEVEL_W] = fifo_level;
					prdata[STATUS_OVF_LSB +: STATUS_OVF_W]     = overflow_count;
				end
				REG_CONTROL: begin
					prdata[CONTROL_MASK_LSB +: NUM_SENSORS] = sensor_mask;
				end
				default: begin
					// Last-distance bank, unmapped offsets read zero
					for (int i = 0; i < NUM_SENSORS; i++) begin
						if (paddr == apb_addr_t'(REG_LAST_DIST0 + i * LAST_DIST_STRIDE))
							prdata[DIST_W-1:0] = last_dist[i];
					end
				end
			endcase
		end
	end

endmodule

//--- robot_cfg_pkg.sv
// Sensing configuration for the robot proximity subsystem
// Channel count, distance and sample widths, scanner states

package robot_cfg_pkg;

	//======================================================================
	//  Channel geometry
	//======================================================================

	localparam int NUM_SENSORS = 4;                   // Ultrasonic channels
	localparam int ID_W        = $clog2(NUM_SENSORS); // Channel index width
	localparam int DIST_W      = 16;                  // Whole centimetres

	typedef logic [ID_W-1:0]        sensor_id_t;   // Channel index
	typedef logic [NUM_SENSORS-1:0] sensor_mask_t; // One bit per channel

	//======================================================================
	//  Distance samples
	//======================================================================

	typedef logic [DIST_W-1:0] dist_t;

	// Reported when the echo never rises
	localparam dist_t NO_ECHO = '1;

	// Sensor id in the top bits, distance below
	typedef logic [ID_W+DIST_W-1:0] sample_t;

	//======================================================================
	//  Ranging engine states
	//======================================================================

	typedef enum logic [2:0] {
		st_idle,       // Pick next enabled channel
		st_trigger,    // Trigger pulse out
		st_wait_echo,  // Waiting for echo rise, timeout running
		st_measure,    // Echo high, counting width
		st_holdoff     // Let the burst die out
	} scan_state_t;

endpackage

//--- robot_sonar_top.sv
// Proximity sensing top level
// Scanner feeds the sample FIFO, host reads it all over APB
`timescale 1ns/1ps

module robot_sonar_top #(
	// Defaults for a 50 MHz clock
	parameter int TRIG_CYCLES    = 500,     // 10 us trigger
	parameter int CYCLES_PER_CM  = 2900,    // 58 us of echo per cm
	parameter int MAX_CM         = 400,
	parameter int ECHO_TIMEOUT   = 50000,   // 1 ms to see the echo rise
	parameter int HOLDOFF_CYCLES = 3000000, // 60 ms between bursts
	parameter int FIFO_DEPTH     = 16
) (
	input  logic                        clock_50,
	input  logic                        reset,
	input  robot_cfg_pkg::sensor_mask_t echo,
	output robot_cfg_pkg::sensor_mask_t trig,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  apb_map_pkg::apb_addr_t      paddr,
	input  apb_map_pkg::apb_data_t      pwdata,
	output apb_map_pkg::apb_data_t      prdata
);
	import robot_cfg_pkg::*;

	//======================================================================
	//  Interconnect
	//======================================================================

	sample_t      sample;
	logic         sample_valid;
	sample_t      fifo_head;
	logic [7:0]   fifo_level;
	logic [15:0]  overflow_count;
	logic         pop;
	logic         clear_overflow;
	sensor_mask_t sensor_mask;

	sonar_scanner #(
		.TRIG_CYCLES    (TRIG_CYCLES),
		.CYCLES_PER_CM  (CYCLES_PER_CM),
		.MAX_CM         (MAX_CM),
		.ECHO_TIMEOUT   (ECHO_TIMEOUT),
		.HOLDOFF_CYCLES (HOLDOFF_CYCLES)
	) u_scanner (
		.clock_50     (clock_50),
		.reset        (reset),
		.sensor_mask  (sensor_mask),
		.echo         (echo),
		.trig         (trig),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clock_50       (clock_50),
		.reset          (reset),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.pop            (pop),
		.clear_overflow (clear_overflow),
		.fifo_head      (fifo_head),
		.fifo_level     (fifo_level),
		.overflow_count (overflow_count)
	);

	apb_telemetry u_regs (
		.clock_50       (clock_50),
		.reset          (reset),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.sample         (sample),       // Taps scanner for last distances
		.sample_valid   (sample_valid),
		.fifo_head      (fifo_head),
		.fifo_level     (fifo_level),
		.overflow_count (overflow_count),
		.pop            (pop),
		.clear_overflow (clear_overflow),
		.sensor_mask    (sensor_mask)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sonar testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -j 0 \
	--top-module tb_robot_sonar \
	-f sources.f \
	-o tb_robot_sonar

# A failing run still leaves its log for the check below
./obj_dir/tb_robot_sonar > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- sample_fifo.sv
// Distance sample FIFO
// Circular buffer, drops on full and counts the drops until cleared
`timescale 1ns/1ps

module sample_fifo #(
	parameter int FIFO_DEPTH = 16 // Power of two, up to 128
) (
	input  logic                   clock_50,
	input  logic                   reset,
	input  robot_cfg_pkg::sample_t sample,
	input  logic                   sample_valid,
	input  logic                   pop,
	input  logic                   clear_overflow,
	output robot_cfg_pkg::sample_t fifo_head,
	output logic [7:0]             fifo_level,
	output logic [15:0]            overflow_count
);
	import robot_cfg_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	sample_t        mem [FIFO_DEPTH];
	logic [AW-1:0]  wr_ptr;  // Wraps naturally
	logic [AW-1:0]  rd_ptr;
	logic           full;
	logic           do_push;
	logic           do_pop;

	assign full    = (fifo_level == 8'(FIFO_DEPTH));
	assign do_pop  = pop && (fifo_level != 8'd0); // Empty pop ignored
	assign do_push = sample_valid && (!full || do_pop); // Full + pop still accepts

	assign fifo_head = mem[rd_ptr];

	//======================================================================
	//  Storage
	//======================================================================

	always_ff @(posedge clock_50) begin
		if (do_push)
			mem[wr_ptr] <= sample;
	end

	//======================================================================
	//  Pointers and level
	//======================================================================

	always_ff @(posedge clock_50) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_level <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   fifo_level <= fifo_level + 1'b1;
				2'b01:   fifo_level <= fifo_level - 1'b1;
				default: fifo_level <= fifo_level; // Both or neither
			endcase
		end
	end

	// Dropped-sample counter, saturating
	always_ff @(posedge clock_50) begin
		if (reset || clear_overflow)
			overflow_count <= '0;
		else if (sample_valid && !do_push && (overflow_count != 16'hFFFF))
			overflow_count <= overflow_count + 1'b1;
	end

endmodule

//--- sonar_scanner.sv
// Round-robin ultrasonic ranging engine
// Fires one channel at a time, times the echo and emits tagged distance samples
`timescale 1ns/1ps

module sonar_scanner #(
	parameter int TRIG_CYCLES    = 500,
	parameter int CYCLES_PER_CM  = 2900,
	parameter int MAX_CM         = 400,
	parameter int ECHO_TIMEOUT   = 50000,
	parameter int HOLDOFF_CYCLES = 3000000
) (
	input  logic                        clock_50,
	input  logic                        reset,
	input  robot_cfg_pkg::sensor_mask_t sensor_mask,
	input  robot_cfg_pkg::sensor_mask_t echo,
	output robot_cfg_pkg::sensor_mask_t trig,
	output robot_cfg_pkg::sample_t      sample,
	output logic                        sample_valid
);
	import robot_cfg_pkg::*;

	// One shared timer covers trigger, timeout and holdoff
	localparam int T_MAX0  = (TRIG_CYCLES > ECHO_TIMEOUT) ? TRIG_CYCLES : ECHO_TIMEOUT;
	localparam int T_MAX   = (T_MAX0 > HOLDOFF_CYCLES) ? T_MAX0 : HOLDOFF_CYCLES;
	localparam int TIMER_W = $clog2(T_MAX + 1);
	localparam int SUB_W   = (CYCLES_PER_CM > 1) ? $clog2(CYCLES_PER_CM) : 1;

	scan_state_t        state;
	sensor_id_t         cur_id;      // Channel in service, also last one served
	sensor_id_t         next_id;     // Round-robin pick
	sensor_id_t         rr_cand;
	logic               next_found;
	logic [TIMER_W-1:0] timer;
	sensor_mask_t       echo_meta;   // First sync stage
	sensor_mask_t       echo_sync;   // Second sync stage
	logic               echo_sel;
	logic               timeout_hit;
	logic               echo_done;
	logic [SUB_W-1:0]   sub_cnt;     // Cycles within the current cm
	dist_t              cm_cnt;      // Whole centimetres so far

	//======================================================================
	//  Echo synchroniser and channel select
	//======================================================================

	always_ff @(posedge clock_50) begin
		if (reset) begin
			echo_meta <= '0;
			echo_sync <= '0;
		end else begin
			echo_meta <= echo;
			echo_sync <= echo_meta;
		end
	end

	assign echo_sel = echo_sync[cur_id];

	// Next enabled channel above cur_id, wrapping, cur_id itself last
	always_comb begin
		next_id    = cur_id;
		next_found = 1'b0;
		rr_cand    = cur_id;
		for (int i = 1; i <= NUM_SENSORS; i++) begin
			rr_cand = sensor_id_t'(cur_id + i);
			if (!next_found && sensor_mask[rr_cand]) begin
				next_id    = rr_cand;
				next_found = 1'b1;
			end
		end
	end

	assign timeout_hit = (state == st_wait_echo) && !echo_sel &&
		(timer == TIMER_W'(ECHO_TIMEOUT - 1));
	assign echo_done   = (state == st_measure) && !echo_sel;

	//======================================================================
	//  Pulse width to centimetres
	//======================================================================

	always_ff @(posedge clock_50) begin
		if (state == st_trigger) begin
			sub_cnt <= '0; // Fresh count per burst
			cm_cnt  <= '0;
		end else if ((state == st_wait_echo || state == st_measure) && echo_sel) begin
			if (sub_cnt == SUB_W'(CYCLES_PER_CM - 1)) begin
				sub_cnt <= '0;
				if (cm_cnt != dist_t'(MAX_CM))
					cm_cnt <= cm_cnt + 1'b1; // Saturates at MAX_CM
			end else begin
				sub_cnt <= sub_cnt + 1'b1;
			end
		end
	end

	// Tagged result word
	always_ff @(posedge clock_50) begin
		if (timeout_hit)
			sample <= {cur_id, NO_ECHO};
		else if (echo_done)
			sample <= {cur_id, cm_cnt};
	end

	//======================================================================
	//  Sequencer
	//======================================================================

	always_ff @(posedge clock_50) begin
		if (reset) begin
			state        <= st_idle;
			cur_id       <= sensor_id_t'(NUM_SENSORS - 1); // First pick is channel 0
			timer        <= '0;
			trig         <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0; // Single-cycle strobe
			case (state)
				st_idle: begin
					if (next_found) begin
						cur_id <= next_id;
						trig   <= sensor_mask_t'(1) << next_id; // One-hot
						timer  <= '0;
						state  <= st_trigger;
					end
				end
				st_trigger: begin
					if (timer == TIMER_W'(TRIG_CYCLES - 1)) begin
						trig  <= '0;
						timer <= '0;
						state <= st_wait_echo;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				st_wait_echo: begin
					if (echo_sel) begin
						state <= st_measure;
					end else if (timeout_hit) begin
						sample_valid <= 1'b1; // NO_ECHO sample
						timer        <= '0;
						state        <= st_holdoff;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				st_measure: begin
					if (echo_done) begin
						sample_valid <= 1'b1;
						timer        <= '0;
						state        <= st_holdoff;
					end
				end
				st_holdoff: begin
					if (timer == TIMER_W'(HOLDOFF_CYCLES - 1))
						state <= st_idle;
					else
						timer <= timer + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- sources.f
robot_cfg_pkg.sv
apb_map_pkg.sv
sonar_scanner.sv
sample_fifo.sv
apb_telemetry.sv
robot_sonar_top.sv
tb_robot_sonar.sv

//--- tb_robot_sonar.sv
// Testbench for the robot proximity sensing top level
// Echo model, APB host tasks and assertions on triggers and register reads
`timescale 1ns/1ps

module tb_robot_sonar;
	import robot_cfg_pkg::*;
	import apb_map_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int TRIG_CYCLES    = 10;
	localparam int CYCLES_PER_CM  = 4;
	localparam int MAX_CM         = 60;
	localparam int ECHO_TIMEOUT   = 200;
	localparam int HOLDOFF_CYCLES = 20;
	localparam int FIFO_DEPTH     = 8;
	localparam int WIDE_CM        = 70;              // Past saturation
	localparam int N_MEAS         = 8 + 4 + 6 + 11;  // All batches
	localparam int WORST_MEAS     = TRIG_CYCLES + ECHO_TIMEOUT + WIDE_CM * CYCLES_PER_CM
		+ 2 + HOLDOFF_CYCLES + 10;

	logic         clock_50;
	logic         reset   = 1'b1;
	sensor_mask_t echo    = '0;
	sensor_mask_t trig;
	logic         psel    = 1'b0;
	logic         penable = 1'b0;
	logic         pwrite  = 1'b0;
	apb_addr_t    paddr   = '0;
	apb_data_t    pwdata  = '0;
	apb_data_t    prdata;

	// Expected samples in trigger order, id above distance
	logic [17:0]  exp_q [$];
	logic [15:0]  exp_last [4];
	int           force_cm [4];   // 0 random, -1 silent, else fixed cm
	int           meas_count;     // Trigger pulses finished
	int           drain_idx;      // Next entry of exp_q to read back
	sensor_mask_t allowed = '0;   // Mirror of CONTROL
	logic         cmp_en  = 1'b0;
	string        cmp_name;
	apb_data_t    cmp_got;
	apb_data_t    cmp_exp;
	sensor_mask_t trig_q  = '0;
	logic         reset_q = 1'b0;
	int           pulse_len;
	sensor_id_t   served;         // Last channel triggered

	robot_sonar_top #(
		.TRIG_CYCLES    (TRIG_CYCLES),
		.CYCLES_PER_CM  (CYCLES_PER_CM),
		.MAX_CM         (MAX_CM),
		.ECHO_TIMEOUT   (ECHO_TIMEOUT),
		.HOLDOFF_CYCLES (HOLDOFF_CYCLES),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) dut (
		.clock_50 (clock_50),
		.reset    (reset),
		.echo     (echo),
		.trig     (trig),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata)
	);

	initial begin
		clock_50 = 1'b0;
		forever #(CLK_PERIOD / 2) clock_50 = ~clock_50;
	end

	function automatic sensor_id_t onehot_to_id(input sensor_mask_t oh);
		case (oh)
			4'b0010: return 2'd1;
			4'b0100: return 2'd2;
			4'b1000: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	// Next enabled channel above the last one, wrapping
	function automatic sensor_mask_t rr_pick(input sensor_id_t last, input sensor_mask_t mask);
		sensor_id_t cand;
		rr_pick = '0;
		for (int k = 1; k <= 4; k++) begin
			cand = last + 2'(k);
			if (rr_pick == '0 && mask[cand])
				rr_pick = 4'b0001 << cand;
		end
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	//======================================================================
	//  APB host
	//======================================================================

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		@(posedge clock_50);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clock_50);
		penable <= 1'b1;
		@(posedge clock_50);  // Access completes here
		psel    <= 1'b0;
		penable <= 1'b0;
		if (addr == REG_CONTROL)
			allowed <= data[3:0];
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
		@(posedge clock_50);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clock_50);
		penable <= 1'b1;
		@(negedge clock_50);
		data = prdata;        // Mid access phase
		@(posedge clock_50);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Held across one rising edge for the compare assertion
	task automatic expect_word(input string name, input apb_data_t got, input apb_data_t exp);
		@(negedge clock_50);
		cmp_name = name;
		cmp_got  = got;
		cmp_exp  = exp;
		cmp_en   = 1'b1;
		@(negedge clock_50);
		cmp_en   = 1'b0;
	endtask

	// Poll STATUS until every finished burst is stored or counted as dropped
	task automatic wait_for_samples();
		apb_data_t rd;
		do
			read_reg(REG_STATUS, rd);
		while (int'(rd[7:0]) + int'(rd[23:8]) != exp_q.size() - drain_idx);
	endtask

	task automatic check_last_dist();
		apb_data_t rd;
		for (int k = 0; k < 4; k++) begin
			read_reg(apb_addr_t'(REG_LAST_DIST0 + 4 * k), rd);
			expect_word($sformatf("LAST_DIST%0d", k), rd, {16'd0, exp_last[2'(k)]});
		end
	endtask

	task automatic drain_samples(input int n);
		apb_data_t rd;
		repeat (n) begin
			read_reg(REG_SAMPLE, rd);
			expect_word("SAMPLE", rd, {1'b1, 13'd0, exp_q[drain_idx]});
			drain_idx++;
		end
		read_reg(REG_SAMPLE, rd);
		expect_word("SAMPLE", rd, 32'd0);  // Empty, valid bit clear
	endtask

	// Scan with a mask for exactly count bursts, then stop and settle
	task automatic run_batch(input sensor_mask_t mask, input int count);
		int target;
		target = meas_count + count;
		write_reg(REG_CONTROL, {28'd0, mask});
		wait (meas_count >= target);
		write_reg(REG_CONTROL, 32'd0);  // Lands before next idle pick
		wait_for_samples();
		check_last_dist();
	endtask

	//======================================================================
	//  Checks
	//======================================================================

	always @(posedge clock_50) begin
		trig_q    <= trig;
		reset_q   <= reset;
		pulse_len <= (trig != '0) ? pulse_len + 1 : 0;
		if (reset)
			served <= 2'd3;  // First pick is channel 0
		else if (trig != '0 && trig_q == '0)
			served <= onehot_to_id(trig);
	end

	a_reset_quiet: assert property (@(posedge clock_50) reset_q |-> trig == '0)
		else abort_run($sformatf("Trigger high during reset: %b", trig));
	a_one_trig: assert property (@(posedge clock_50) disable iff (reset) $onehot0(trig))
		else abort_run($sformatf("More than one trigger high at once: %b", trig));
	a_rr_order: assert property (@(posedge clock_50) disable iff (reset)
		(trig != '0 && $past(trig) == '0) |-> trig == rr_pick(served, allowed))
		else abort_run($sformatf("Trigger %b is not the next enabled channel (mask %b)",
			trig, allowed));
	a_pulse_len: assert property (@(posedge clock_50) disable iff (reset)
		(trig == '0 && $past(trig) != '0) |-> pulse_len == TRIG_CYCLES)
		else abort_run($sformatf("Trigger pulse lasted %0d cycles", pulse_len));
	a_reg_value: assert property (@(posedge clock_50) cmp_en |-> cmp_got == cmp_exp)
		else abort_run($sformatf("MISMATCH at %0d ns: %s read %h, expected %h",
			$time, cmp_name, cmp_got, cmp_exp));

	//======================================================================
	//  Echo model and stimulus
	//======================================================================

	// Answers whichever sensor just finished its trigger
	initial begin : echo_model
		sensor_mask_t prev;
		sensor_id_t   g;
		int           cm;
		int           width;
		int           gap;
		logic [15:0]  exp_d;
		void'($urandom(32'h8ca1));
		prev = '0;
		foreach (exp_last[k])
			exp_last[k] = '0;
		forever begin
			@(posedge clock_50);
			if (!reset && prev != '0 && trig == '0) begin
				g     = onehot_to_id(prev);
				cm    = (force_cm[g] == 0) ? int'($urandom_range(50, 1)) : force_cm[g];
				width = cm * CYCLES_PER_CM + 2;  // Clear of rounding edges
				if (cm < 0)
					exp_d = '1;                  // No echo reads all ones
				else if (width / CYCLES_PER_CM > MAX_CM)
					exp_d = 16'(MAX_CM);
				else
					exp_d = 16'(width / CYCLES_PER_CM);
				exp_q.push_back({g, exp_d});
				exp_last[g] = exp_d;
				meas_count++;
				gap = $urandom_range(50, 5);
				repeat (gap) @(posedge clock_50);
				if (cm >= 0) begin
					echo[g] <= 1'b1;
					repeat (width) @(posedge clock_50);
					echo[g] <= 1'b0;
				end
			end
			prev = trig;
		end
	end

	initial begin : stimulus
		apb_data_t rd;
		repeat (10) @(posedge clock_50);
		reset <= 1'b0;
		read_reg(REG_STATUS, rd);
		expect_word("STATUS", rd, 32'd0);
		read_reg(REG_SAMPLE, rd);
		expect_word("SAMPLE", rd, 32'd0);
		read_reg(REG_CONTROL, rd);
		expect_word("CONTROL", rd, 32'd0);
		run_batch(4'b1111, 8);              // Two full rounds
		drain_samples(8);
		force_cm = '{-1, WIDE_CM, 0, 0};    // Silent and too far
		run_batch(4'b1111, 4);
		drain_samples(4);
		force_cm = '{0, 0, 0, 0};
		run_batch(4'b0101, 6);              // Channels 0 and 2 only
		drain_samples(6);
		run_batch(4'b1111, 11);             // Host idle, FIFO overruns
		read_reg(REG_STATUS, rd);
		expect_word("STATUS", rd, {8'd0, 16'(11 - FIFO_DEPTH), 8'(FIFO_DEPTH)});
		drain_samples(FIFO_DEPTH);
		drain_idx = drain_idx + 11 - FIFO_DEPTH;  // Skip the dropped ones
		write_reg(REG_STATUS, 32'hFFFF_FFFF);
		read_reg(REG_STATUS, rd);
		expect_word("STATUS", rd, 32'd0);
		$display("RESULT: PASS");
		$finish;
	end

	initial begin : watchdog
		#(N_MEAS * WORST_MEAS * 2 * CLK_PERIOD);
		abort_run("Timeout: the measurements did not finish in the expected time");
	end

endmodule
